// ==== design/mem_pkg.sv ====
package mem_pkg;

    // data and address word of the core port.
    typedef logic [31:0] word_t;

    // one stored word, seen whole or as four byte lanes.
    typedef union packed {
        word_t           word;  // word view, used for reads.
        logic [3:0][7:0] lane;  // lane 0 is the low byte.
    } mem_word_u;

    // target selected by the address decode.
    typedef enum logic [1:0] {
        rom      = 2'd0,
        ram      = 2'd1,
        unmapped = 2'd2
    } region_e;

    // region field is addr[31:28].
    localparam int unsigned REGION_LSB = 28;

    localparam logic [3:0] ROM_REGION = 4'h0;  // 0x0xxx_xxxx.
    localparam logic [3:0] RAM_REGION = 4'h1;  // 0x1xxx_xxxx.

    // boot stub size in words.
    localparam int unsigned BOOT_WORDS = 4;

    // boot stub, index 0 executes first.
    // builds the ram base 0x1000_0000 in a0 and jumps there.
    localparam word_t BOOT_IMAGE [BOOT_WORDS] = '{
        32'h01000537,  // lui  a0, 0x01000.
        32'h00451513,  // slli a0, a0, 4.
        32'h000500e7,  // jalr ra, 0(a0).
        32'h0000006f   // j    . (parks here if the jump returns).
    };

    // default ram size in words, 1 KiB.
    localparam int unsigned RAM_DEPTH_DEFAULT = 256;

endpackage

// ==== design/boot_rom.sv ====
module boot_rom (
    input  logic          clk_i,
    input  logic          rst_ni,

    input  logic          req_i,     // request strobe, already decoded.
    input  mem_pkg::word_t addr_i,   // byte address.
    output logic          rvalid_o,  // one cycle after req_i.
    output mem_pkg::word_t rdata_o
);

    import mem_pkg::*;

    // word index spans the whole rom region.
    localparam int unsigned IdxW = REGION_LSB - 2;
    // bits needed to pick one image word.
    localparam int unsigned SelW = $clog2(BOOT_WORDS);

    logic [IdxW-1:0] idx_q;  // word index of the last request.
    logic            rvalid_q;

    // capture the index on every request.
    // byte offset bits are dropped.
    always_ff @(posedge clk_i) begin
        if (req_i) begin
            idx_q <= addr_i[REGION_LSB-1:2];
        end
    end

    // response strobe follows the request.
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            rvalid_q <= 1'b0;
        end else begin
            rvalid_q <= req_i;
        end
    end

    // image lookup from the held index.
    // anything past the stub reads as zero.
    always_comb begin
        rdata_o = '0;
        if (idx_q < IdxW'(BOOT_WORDS)) begin
            rdata_o = BOOT_IMAGE[idx_q[SelW-1:0]];
        end
    end

    // writes have no path into the image.
    // a write request still gets its rvalid.
    assign rvalid_o = rvalid_q;

endmodule

// ==== design/data_ram.sv ====
module data_ram #(
    parameter int unsigned RamDepth = mem_pkg::RAM_DEPTH_DEFAULT  // words, power of two.
) (
    input  logic          clk_i,
    input  logic          rst_ni,

    input  logic          req_i,     // request strobe, already decoded.
    input  logic          we_i,      // write when high.
    input  logic [3:0]    be_i,      // one enable per byte lane.
    input  mem_pkg::word_t addr_i,   // byte address.
    input  mem_pkg::word_t wdata_i,
    output logic          rvalid_o,  // one cycle after req_i.
    output mem_pkg::word_t rdata_o   // word stored before this write.
);

    import mem_pkg::*;

    // index bits above the byte offset.
    localparam int unsigned AddrW = $clog2(RamDepth);

    logic [AddrW-1:0] idx;       // word index of this request.
    mem_word_u        wdata_u;   // write data split into lanes.
    mem_word_u        mem_q [RamDepth];
    word_t            rdata_q;
    logic             rvalid_q;

    // upper index bits ignored.
    // addresses past the end wrap around.
    assign idx = addr_i[AddrW+1:2];

    assign wdata_u.word = wdata_i;

    // storage and read port.
    // read sees the old word, the write lands at the same edge.
    always_ff @(posedge clk_i) begin
        if (req_i) begin
            rdata_q <= mem_q[idx].word;  // word view.
            if (we_i) begin
                for (int i = 0; i < 4; i++) begin
                    if (be_i[i]) begin
                        mem_q[idx].lane[i] <= wdata_u.lane[i];  // lane view.
                    end
                end
            end
        end
    end

    // response strobe for reads and writes alike.
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            rvalid_q <= 1'b0;
        end else begin
            rvalid_q <= req_i;
        end
    end

    assign rvalid_o = rvalid_q;
    assign rdata_o  = rdata_q;  // holds until the next request.

endmodule

// ==== design/mem_resp_mux.sv ====
module mem_resp_mux (
    input  logic          clk_i,
    input  logic          rst_ni,

    // core request side.
    input  logic          req_i,
    input  mem_pkg::word_t addr_i,
    output logic          gnt_o,

    // target strobes.
    output logic          rom_req_o,
    output logic          ram_req_o,

    // target responses.
    input  logic          rom_rvalid_i,
    input  mem_pkg::word_t rom_rdata_i,
    input  logic          ram_rvalid_i,
    input  mem_pkg::word_t ram_rdata_i,

    // core response side.
    output logic          rvalid_o,
    output mem_pkg::word_t rdata_o,
    output logic          err_o      // unmapped access, valid with rvalid_o.
);

    import mem_pkg::*;

    region_e region_d;  // decode of the current request.
    region_e region_q;  // region of the response in flight.
    logic    req_q;     // a response is due this cycle.

    // region decode on addr[31:28].
    always_comb begin
        case (addr_i[31:REGION_LSB])
            ROM_REGION: region_d = rom;
            RAM_REGION: region_d = ram;
            default:    region_d = unmapped;
        endcase
    end

    // no wait states, every request is taken.
    assign gnt_o = req_i;

    // at most one strobe, none for unmapped.
    assign rom_req_o = req_i && (region_d == rom);
    assign ram_req_o = req_i && (region_d == ram);

    // remember where the response will come from.
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            region_q <= unmapped;
            req_q    <= 1'b0;
        end else begin
            req_q <= req_i;
            if (req_i) begin
                region_q <= region_d;  // held while idle.
            end
        end
    end

    // response steering.
    always_comb begin
        rvalid_o = 1'b0;
        rdata_o  = '0;
        err_o    = 1'b0;
        case (region_q)
            rom: begin
                rvalid_o = rom_rvalid_i;
                rdata_o  = rom_rdata_i;
            end
            ram: begin
                rvalid_o = ram_rvalid_i;
                rdata_o  = ram_rdata_i;
            end
            default: begin
                // nobody answers, so the mux does.
                rvalid_o = req_q;
                err_o    = req_q;  // zero data with the error.
            end
        endcase
    end

endmodule

// ==== design/mem_subsys_top.sv ====
module mem_subsys_top #(
    parameter int unsigned RamDepth = mem_pkg::RAM_DEPTH_DEFAULT  // ram words.
) (
    input  logic          clk_i,
    input  logic          rst_ni,

    // request from the core.
    input  logic          req_i,
    input  logic          we_i,
    input  logic [3:0]    be_i,
    input  mem_pkg::word_t addr_i,
    input  mem_pkg::word_t wdata_i,
    output logic          gnt_o,

    // response to the core.
    output logic          rvalid_o,
    output mem_pkg::word_t rdata_o,
    output logic          err_o
);

    import mem_pkg::*;

    logic  rom_req;     // strobe into the rom.
    logic  ram_req;     // strobe into the ram.
    logic  rom_rvalid;
    word_t rom_rdata;
    logic  ram_rvalid;
    word_t ram_rdata;

    // decode and response mux.
    mem_resp_mux u_mux (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .req_i        (req_i),
        .addr_i       (addr_i),
        .gnt_o        (gnt_o),
        .rom_req_o    (rom_req),
        .ram_req_o    (ram_req),
        .rom_rvalid_i (rom_rvalid),
        .rom_rdata_i  (rom_rdata),
        .ram_rvalid_i (ram_rvalid),
        .ram_rdata_i  (ram_rdata),
        .rvalid_o     (rvalid_o),
        .rdata_o      (rdata_o),
        .err_o        (err_o)
    );

    // boot image at 0x0000_0000.
    boot_rom u_rom (
        .clk_i    (clk_i),
        .rst_ni   (rst_ni),
        .req_i    (rom_req),
        .addr_i   (addr_i),
        .rvalid_o (rom_rvalid),
        .rdata_o  (rom_rdata)
    );

    // data ram at 0x1000_0000.
    data_ram #(
        .RamDepth (RamDepth)
    ) u_ram (
        .clk_i    (clk_i),
        .rst_ni   (rst_ni),
        .req_i    (ram_req),
        .we_i     (we_i),
        .be_i     (be_i),
        .addr_i   (addr_i),
        .wdata_i  (wdata_i),
        .rvalid_o (ram_rvalid),
        .rdata_o  (ram_rdata)
    );

endmodule

// ==== bench/mem_subsys_tb.sv ====
module mem_subsys_tb;

    timeunit 1ns;
    timeprecision 1ps;

    import mem_pkg::*;

    localparam int unsigned RAM_DEPTH    = 64;                  // words in the dut ram.
    localparam word_t       RAM_BASE     = {RAM_REGION, 28'h0};  // first ram byte.
    localparam int unsigned RESP_TIMEOUT = 8;                   // cycles to wait for rvalid.

    // byte enable mix for the partial writes.
    localparam logic [3:0] BE_PATTERNS [12] = '{
        4'b0001, 4'b0010, 4'b0100, 4'b1000, 4'b0011, 4'b1100,
        4'b0101, 4'b1010, 4'b0000, 4'b1111, 4'b0110, 4'b1001
    };

    // one table row holds stimulus and expected response.
    typedef struct packed {
        logic       req;
        logic       we;
        logic [3:0] be;
        word_t      addr;
        word_t      wdata;
        word_t      exp_data;
        logic       exp_err;
        logic       chk_data;  // data compared on the response.
        logic       idle;      // idle cycle follows and the response lands in it.
    } stim_t;

    logic       clk_i = 1'b0;
    logic       rst_ni;
    logic       req_i;
    logic       we_i;
    logic [3:0] be_i;
    word_t      addr_i;
    word_t      wdata_i;
    logic       gnt_o;
    logic       rvalid_o;
    word_t      rdata_o;
    logic       err_o;

    stim_t  stim_q [$];             // the stimulus table.
    word_t  ram_model [RAM_DEPTH];  // expected ram contents.
    integer seed = 32'hb6d1f35f;

    mem_subsys_top #(
        .RamDepth (RAM_DEPTH)
    ) u_mem_subsys_top (
        .clk_i    (clk_i),
        .rst_ni   (rst_ni),
        .req_i    (req_i),
        .we_i     (we_i),
        .be_i     (be_i),
        .addr_i   (addr_i),
        .wdata_i  (wdata_i),
        .gnt_o    (gnt_o),
        .rvalid_o (rvalid_o),
        .rdata_o  (rdata_o),
        .err_o    (err_o)
    );

    always #10 clk_i = ~clk_i;  // 20 ns period.

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("tests failed");
        $fatal(1, "stopped at the first failure.");
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            abort_run($sformatf("error: %s got 0x%08h expected 0x%08h", name, got, exp));
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            abort_run($sformatf("error: %s got 0x%0h expected 0x%0h", name, got, exp));
        end
    endtask

    // byte lane merge of a write into a stored word.
    function automatic word_t merge_lanes(input word_t old_word, input word_t new_word,
                                          input logic [3:0] be);
        word_t res;
        int    i;
        res = old_word;
        for (i = 0; i < 4; i++) begin
            if (be[i]) begin
                res[8*i +: 8] = new_word[8*i +: 8];  // enabled lane only.
            end
        end
        return res;
    endfunction

    // adds one request row with expected values from the address map.
    task automatic add_req(input logic we, input logic [3:0] be, input word_t addr,
                           input word_t wdata, input logic idle);
        stim_t       e;
        int unsigned widx;
        e          = '0;
        e.req      = 1'b1;
        e.we       = we;
        e.be       = be;
        e.addr     = addr;
        e.wdata    = wdata;
        e.idle     = idle;
        e.chk_data = !we;  // write data return carries no meaning.
        case (addr[31:28])
            ROM_REGION: begin
                widx = addr[27:2];
                if (widx < BOOT_WORDS) begin
                    e.exp_data = BOOT_IMAGE[widx];
                end
            end
            RAM_REGION: begin
                widx       = (addr[27:0] >> 2) % RAM_DEPTH;  // wraps inside the region.
                e.exp_data = ram_model[widx];              // read before write.
                if (we) begin
                    ram_model[widx] = merge_lanes(ram_model[widx], wdata, be);
                end
            end
            default: begin
                e.exp_err  = 1'b1;  // zero data with the error.
                e.chk_data = 1'b1;
            end
        endcase
        stim_q.push_back(e);
    endtask

    // row with no request.
    task automatic add_bubble();
        stim_t e;
        e = '0;
        stim_q.push_back(e);
    endtask

    task automatic build_table();
        int    i;
        word_t off;
        for (i = 0; i < 6; i++) begin
            add_req(1'b0, 4'hf, i * 4, '0, 1'b1);  // image words and then zeros past it.
        end
        add_req(1'b0, 4'hf, 32'h0000_0102, '0, 1'b1);  // far rom index with a byte offset.
        for (i = 0; i < 8; i++) begin
            add_req(1'b1, 4'hf, RAM_BASE + i * 4, $random(seed), 1'b1);  // fill.
        end
        for (i = 0; i < 12; i++) begin
            off = ($random(seed) & 7) << 2;
            add_req(1'b1, BE_PATTERNS[i], RAM_BASE + off, $random(seed), 1'b1);
        end
        for (i = 0; i < 8; i++) begin
            add_req(1'b0, 4'hf, RAM_BASE + i * 4, '0, 1'b1);  // read back.
        end
        add_req(1'b1, 4'b0110, RAM_BASE + (RAM_DEPTH + 3) * 4, $random(seed), 1'b1);
        add_req(1'b0, 4'hf, RAM_BASE + 12, '0, 1'b1);                      // alias hit.
        add_req(1'b0, 4'hf, RAM_BASE + (2 * RAM_DEPTH + 3) * 4, '0, 1'b1);
        add_req(1'b1, 4'hf, 32'h0000_0008, 32'hdead_beef, 1'b1);  // dropped rom write.
        add_req(1'b0, 4'hf, 32'h0000_0008, '0, 1'b1);
        add_req(1'b0, 4'hf, 32'h2000_0000, '0, 1'b1);  // unmapped read.
        add_req(1'b0, 4'hf, 32'h0000_000c, '0, 1'b1);  // err clears.
        add_req(1'b1, 4'hf, 32'hf000_0010, 32'h1234_5678, 1'b1);
        add_req(1'b0, 4'hf, RAM_BASE + 16, '0, 1'b1);  // word the unmapped write would hit.
        // back to back from here.
        add_req(1'b0, 4'hf, 32'h0000_0000, '0, 1'b0);
        add_req(1'b0, 4'hf, RAM_BASE + 8, '0, 1'b0);
        add_req(1'b0, 4'hf, 32'h3000_0004, '0, 1'b0);
        add_req(1'b1, 4'b0011, RAM_BASE + 8, $random(seed), 1'b0);
        add_req(1'b0, 4'hf, RAM_BASE + 8, '0, 1'b0);  // sees the write just before.
        add_req(1'b0, 4'hf, 32'h0000_0010, '0, 1'b0);
        add_bubble();
        add_req(1'b1, 4'hf, 32'h8000_0000, '0, 1'b0);
        add_req(1'b0, 4'hf, 32'h0000_0004, '0, 1'b0);
        for (i = 0; i < 12; i++) begin
            off = ($random(seed) & 7) << 2;
            case (i % 3)
                0:       add_req(1'b0, 4'hf, off, '0, 1'b0);  // rom reads that may pass the image.
                1:       add_req(1'b0, 4'hf, RAM_BASE + off, '0, 1'b0);
                default: add_req(1'b0, 4'hf, 32'h5000_0000 + off, '0, 1'b0);
            endcase
        end
        add_req(1'b0, 4'hf, RAM_BASE + (RAM_DEPTH + 2) * 4, '0, 1'b1);  // last one drains.
    endtask

    // checks the response of row idx at the falling edge.
    task automatic check_response(input int idx);
        stim_t e;
        e = stim_q[idx];
        check_flag("rvalid_o", rvalid_o, 1'b1);
        check_flag("err_o", err_o, e.exp_err);
        if (e.chk_data) begin
            check_word("rdata_o", rdata_o, e.exp_data);
        end
    endtask

    // idle the port and wait for the response of row idx.
    task automatic await_response(input int idx);
        int   n;
        logic seen;
        n    = 0;
        seen = 1'b0;
        @(posedge clk_i);
        req_i <= 1'b0;
        while (!seen && n < RESP_TIMEOUT) begin
            @(negedge clk_i);
            n++;
            seen = (rvalid_o === 1'b1);
        end
        if (!seen) begin
            abort_run($sformatf("no response arrived within %0d cycles for request %0d",
                                RESP_TIMEOUT, idx));
        end
        if (n != 1) begin
            abort_run($sformatf("response to request %0d arrived after %0d cycles, not one",
                                idx, n));
        end
        check_response(idx);
    endtask

    initial begin
        stim_t e;
        int    i;
        int    c;
        logic  pend;
        rst_ni  = 1'b0;
        req_i   = 1'b0;
        we_i    = 1'b0;
        be_i    = 4'h0;
        addr_i  = '0;
        wdata_i = '0;
        pend    = 1'b0;
        build_table();

        // reset with one request inside it.
        for (c = 0; c < 5; c++) begin
            @(posedge clk_i);
            req_i  <= (c == 2);
            addr_i <= 32'h2000_0000;  // unmapped so no target strobe fires.
            @(negedge clk_i);
            check_flag("gnt_o", gnt_o, c == 2);
            check_flag("rvalid_o", rvalid_o, 1'b0);
            check_flag("err_o", err_o, 1'b0);
        end
        @(posedge clk_i);
        rst_ni <= 1'b1;
        req_i  <= 1'b0;
        @(negedge clk_i);
        check_flag("rvalid_o", rvalid_o, 1'b0);  // nothing left over from reset.
        check_flag("err_o", err_o, 1'b0);

        for (i = 0; i < stim_q.size(); i++) begin
            e = stim_q[i];
            @(posedge clk_i);
            req_i   <= e.req;
            we_i    <= e.we;
            be_i    <= e.be;
            addr_i  <= e.addr;
            wdata_i <= e.wdata;
            @(negedge clk_i);
            check_flag("gnt_o", gnt_o, e.req);  // same cycle grant.
            if (pend) begin
                check_response(i - 1);  // row before answers one cycle on.
            end else begin
                check_flag("rvalid_o", rvalid_o, 1'b0);
            end
            pend = e.req && !e.idle;
            if (e.req && e.idle) begin
                await_response(i);
            end
        end
        if (pend) begin
            await_response(stim_q.size() - 1);
        end

        $display("all tests passed");
        $finish;
    end

endmodule

// ==== filelist.f ====
design/mem_pkg.sv
design/boot_rom.sv
design/data_ram.sv
design/mem_resp_mux.sv
design/mem_subsys_top.sv
bench/mem_subsys_tb.sv
